// ==== ooo_pkg.sv ====
////////////////////////////////////////
// shared widths and opcodes of the core slice
// ROB_DEPTH and RS_DEPTH must be powers of two
////////////////////////////////////////
package ooo_pkg;

	// datapath
	localparam int XLEN = 32;
	localparam int SHAMT_W = 5;

	// architectural registers
	localparam int REG_COUNT = 32;
	localparam int REG_IDX_W = 5;

	// reorder buffer
	localparam int ROB_DEPTH = 8;
	localparam int ROB_TAG_W = 3;
	localparam int ROB_CNT_W = 4;
	localparam int COMMIT_CNT_W = 16;

	// reservation station
	localparam int RS_DEPTH = 4;
	localparam int RS_IDX_W = 2;
	localparam int RS_CNT_W = 3;

	// dispatched opcodes
	typedef enum logic [3:0] {
		op_add  = 4'd0,
		op_sub  = 4'd1,
		op_and  = 4'd2,
		op_or   = 4'd3,
		op_xor  = 4'd4,
		op_sll  = 4'd5,
		op_srl  = 4'd6,
		op_slt  = 4'd7,
		op_addi = 4'd8
	} inst_op_e;

	// ALU operations, addi folds into add
	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll, alu_srl, alu_slt
	} alu_op_e;

endpackage

// ==== alu_unit.sv ====
////////////////////////////////////////
// one-cycle ALU, result registered onto the bus
////////////////////////////////////////
module alu_unit
	import ooo_pkg::*;
(
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 issue_valid,
	input  alu_op_e              issue_op,
	input  logic [ROB_TAG_W-1:0] issue_tag,
	input  logic [XLEN-1:0]      issue_a,
	input  logic [XLEN-1:0]      issue_b,
	output logic                 cdb_valid,
	output logic [ROB_TAG_W-1:0] cdb_tag,
	output logic [XLEN-1:0]      cdb_value
);

	logic [XLEN-1:0] result;
	logic less;

	// signed compare for slt
	assign less = $signed(issue_a) < $signed(issue_b);

	always_comb begin
		case (issue_op)
			alu_add: result = issue_a + issue_b;
			alu_sub: result = issue_a - issue_b;
			alu_and: result = issue_a & issue_b;
			alu_or: result = issue_a | issue_b;
			alu_xor: result = issue_a ^ issue_b;
			// shift amount from the low bits of b
			alu_sll: result = issue_a << issue_b[SHAMT_W-1:0];
			alu_srl: result = issue_a >> issue_b[SHAMT_W-1:0];
			alu_slt: result = {{(XLEN-1){1'b0}}, less};
			default: result = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= issue_valid;
		end
	end

	always_ff @(posedge clock) begin
		cdb_tag <= issue_tag;
		cdb_value <= result;
	end

endmodule

// ==== reorder_buffer.sv ====
////////////////////////////////////////
// circular rob, in-order commit, one per cycle
// commit_valid is combinational from the head entry
////////////////////////////////////////
module reorder_buffer
	import ooo_pkg::*;
(
	input  logic                    clock,
	input  logic                    rst,
	input  logic                    alloc_en,
	input  logic [REG_IDX_W-1:0]    alloc_rd,
	input  logic [ROB_TAG_W-1:0]    rob_a_tag,
	input  logic [ROB_TAG_W-1:0]    rob_b_tag,
	input  logic                    cdb_valid,
	input  logic [ROB_TAG_W-1:0]    cdb_tag,
	input  logic [XLEN-1:0]         cdb_value,
	output logic [ROB_TAG_W-1:0]    rob_tail_tag,
	output logic [ROB_CNT_W-1:0]    rob_free,
	output logic                    rob_a_done,
	output logic [XLEN-1:0]         rob_a_value,
	output logic                    rob_b_done,
	output logic [XLEN-1:0]         rob_b_value,
	output logic                    commit_valid,
	output logic [REG_IDX_W-1:0]    commit_rd,
	output logic [ROB_TAG_W-1:0]    commit_tag,
	output logic [XLEN-1:0]         commit_data,
	output logic [COMMIT_CNT_W-1:0] commit_count
);

	logic [REG_IDX_W-1:0] rob_rd [ROB_DEPTH];
	logic [XLEN-1:0] rob_value [ROB_DEPTH];
	logic [ROB_DEPTH-1:0] rob_done;

	// pointers wrap on their own, depth is a power of two
	logic [ROB_TAG_W-1:0] head, tail;
	logic [ROB_CNT_W-1:0] used;

	assign rob_tail_tag = tail;
	assign rob_free = ROB_CNT_W'(ROB_DEPTH) - used;

	// operand lookups for dispatch
	assign rob_a_done = rob_done[rob_a_tag];
	assign rob_a_value = rob_value[rob_a_tag];
	assign rob_b_done = rob_done[rob_b_tag];
	assign rob_b_value = rob_value[rob_b_tag];

	// done is cleared at commit, so a free head never looks done
	assign commit_valid = rob_done[head];
	assign commit_rd = rob_rd[head];
	assign commit_tag = head;
	assign commit_data = rob_value[head];

	always_ff @(posedge clock) begin
		if (rst) begin
			head <= '0;
			tail <= '0;
			used <= '0;
			rob_done <= '0;
			commit_count <= '0;
		end else begin
			if (alloc_en) begin
				rob_done[tail] <= 1'b0;
				tail <= tail + 1'b1;
			end
			// completion from the bus
			if (cdb_valid) begin
				rob_done[cdb_tag] <= 1'b1;
			end
			if (commit_valid) begin
				rob_done[head] <= 1'b0;
				head <= head + 1'b1;
				commit_count <= commit_count + 1'b1;
			end
			case ({alloc_en, commit_valid})
				2'b10: used <= used + 1'b1;
				2'b01: used <= used - 1'b1;
				default: used <= used;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (alloc_en) begin
			rob_rd[tail] <= alloc_rd;
		end
		if (cdb_valid) begin
			rob_value[cdb_tag] <= cdb_value;
		end
	end

endmodule

// ==== reservation_station.sv ====
////////////////////////////////////////
// waiting ALU ops, woken by the common data bus
// issues the oldest ready entry, one per cycle
////////////////////////////////////////
module reservation_station
	import ooo_pkg::*;
(
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 insert_en,
	input  alu_op_e              insert_op,
	input  logic [ROB_TAG_W-1:0] insert_tag,
	input  logic                 a_ready,
	input  logic [ROB_TAG_W-1:0] a_tag,
	input  logic [XLEN-1:0]      a_value,
	input  logic                 b_ready,
	input  logic [ROB_TAG_W-1:0] b_tag,
	input  logic [XLEN-1:0]      b_value,
	input  logic                 cdb_valid,
	input  logic [ROB_TAG_W-1:0] cdb_tag,
	input  logic [XLEN-1:0]      cdb_value,
	output logic [RS_CNT_W-1:0]  rs_free,
	output logic                 issue_valid,
	output alu_op_e              issue_op,
	output logic [ROB_TAG_W-1:0] issue_tag,
	output logic [XLEN-1:0]      issue_a,
	output logic [XLEN-1:0]      issue_b
);

	// entry storage
	logic [RS_DEPTH-1:0] ent_valid;
	alu_op_e ent_op [RS_DEPTH];
	logic [ROB_TAG_W-1:0] ent_tag [RS_DEPTH];
	logic [RS_DEPTH-1:0] ent_a_rdy, ent_b_rdy;
	logic [ROB_TAG_W-1:0] ent_a_tag [RS_DEPTH];
	logic [ROB_TAG_W-1:0] ent_b_tag [RS_DEPTH];
	logic [XLEN-1:0] ent_a_val [RS_DEPTH];
	logic [XLEN-1:0] ent_b_val [RS_DEPTH];

	// tag of the last inserted op, the age reference
	logic [ROB_TAG_W-1:0] newest_tag;
	logic [RS_IDX_W-1:0] issue_idx, free_idx;

	////////////////////////////////////////
	// oldest-ready select
	////////////////////////////////////////
	// age is the tag distance back from the newest insert
	// all live tags sit within one rob window of it
	always_comb begin
		logic [ROB_TAG_W-1:0] age;
		logic [ROB_TAG_W-1:0] best_age;
		issue_valid = 1'b0;
		issue_idx = '0;
		best_age = '0;
		for (int i = 0; i < RS_DEPTH; i++) begin
			age = newest_tag - ent_tag[i];
			if (ent_valid[i] && ent_a_rdy[i] && ent_b_rdy[i] &&
				(!issue_valid || age > best_age)) begin
				issue_valid = 1'b1;
				issue_idx = RS_IDX_W'(i);
				best_age = age;
			end
		end
	end

	assign issue_op = ent_op[issue_idx];
	assign issue_tag = ent_tag[issue_idx];
	assign issue_a = ent_a_val[issue_idx];
	assign issue_b = ent_b_val[issue_idx];

	// free count and lowest free slot
	always_comb begin
		rs_free = '0;
		free_idx = '0;
		for (int i = RS_DEPTH - 1; i >= 0; i--) begin
			if (!ent_valid[i]) begin
				rs_free = rs_free + 1'b1;
				free_idx = RS_IDX_W'(i);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			ent_valid <= '0;
			newest_tag <= '0;
		end else begin
			if (issue_valid) begin
				ent_valid[issue_idx] <= 1'b0;
			end
			// stall upstream guarantees a free slot here
			if (insert_en) begin
				ent_valid[free_idx] <= 1'b1;
				newest_tag <= insert_tag;
			end
		end
	end

	always_ff @(posedge clock) begin
		// bus wakeup of waiting operands
		for (int i = 0; i < RS_DEPTH; i++) begin
			if (cdb_valid && !ent_a_rdy[i] && ent_a_tag[i] == cdb_tag) begin
				ent_a_rdy[i] <= 1'b1;
				ent_a_val[i] <= cdb_value;
			end
			if (cdb_valid && !ent_b_rdy[i] && ent_b_tag[i] == cdb_tag) begin
				ent_b_rdy[i] <= 1'b1;
				ent_b_val[i] <= cdb_value;
			end
		end
		// new entry, bus already folded in by dispatch
		if (insert_en) begin
			ent_op[free_idx] <= insert_op;
			ent_tag[free_idx] <= insert_tag;
			ent_a_rdy[free_idx] <= a_ready;
			ent_a_tag[free_idx] <= a_tag;
			ent_a_val[free_idx] <= a_value;
			ent_b_rdy[free_idx] <= b_ready;
			ent_b_tag[free_idx] <= b_tag;
			ent_b_val[free_idx] <= b_value;
		end
	end

endmodule

// ==== reg_state.sv ====
////////////////////////////////////////
// committed registers with busy bit and producer tag
// x0 reads zero and never goes busy
////////////////////////////////////////
module reg_state
	import ooo_pkg::*;
(
	input  logic                 clock,
	input  logic                 rst,
	input  logic [REG_IDX_W-1:0] rs1_idx,
	input  logic [REG_IDX_W-1:0] rs2_idx,
	input  logic                 rename_en,
	input  logic [REG_IDX_W-1:0] rename_rd,
	input  logic [ROB_TAG_W-1:0] rename_tag,
	input  logic                 commit_valid,
	input  logic [REG_IDX_W-1:0] commit_rd,
	input  logic [ROB_TAG_W-1:0] commit_tag,
	input  logic [XLEN-1:0]      commit_data,
	output logic                 rs1_busy,
	output logic [ROB_TAG_W-1:0] rs1_tag,
	output logic [XLEN-1:0]      rs1_value,
	output logic                 rs2_busy,
	output logic [ROB_TAG_W-1:0] rs2_tag,
	output logic [XLEN-1:0]      rs2_value
);

	logic [XLEN-1:0] reg_value [REG_COUNT];
	logic [REG_COUNT-1:0] reg_busy;
	logic [ROB_TAG_W-1:0] reg_tag [REG_COUNT];

	// two read ports, index 0 is rs1
	logic [1:0][REG_IDX_W-1:0] src_idx;
	logic [1:0] src_busy;
	logic [1:0][ROB_TAG_W-1:0] src_tag;
	logic [1:0][XLEN-1:0] src_value;

	assign src_idx[0] = rs1_idx;
	assign src_idx[1] = rs2_idx;

	always_comb begin
		for (int p = 0; p < 2; p++) begin
			src_busy[p] = 1'b0;
			src_tag[p] = '0;
			src_value[p] = '0;
			if (src_idx[p] != '0) begin
				src_busy[p] = reg_busy[src_idx[p]];
				src_tag[p] = reg_tag[src_idx[p]];
				src_value[p] = reg_value[src_idx[p]];
				// write-through of a commit in this cycle
				if (commit_valid && commit_rd == src_idx[p]) begin
					src_value[p] = commit_data;
					if (reg_tag[src_idx[p]] == commit_tag) begin
						src_busy[p] = 1'b0;
					end
				end
			end
		end
	end

	assign rs1_busy = src_busy[0];
	assign rs1_tag = src_tag[0];
	assign rs1_value = src_value[0];
	assign rs2_busy = src_busy[1];
	assign rs2_tag = src_tag[1];
	assign rs2_value = src_value[1];

	always_ff @(posedge clock) begin
		if (rst) begin
			reg_busy <= '0;
			for (int i = 0; i < REG_COUNT; i++) begin
				reg_value[i] <= '0;
			end
		end else begin
			if (commit_valid && commit_rd != '0) begin
				reg_value[commit_rd] <= commit_data;
				// only the latest producer frees the register
				if (reg_tag[commit_rd] == commit_tag) begin
					reg_busy[commit_rd] <= 1'b0;
				end
			end
			// rename wins over a same-cycle commit
			if (rename_en && rename_rd != '0) begin
				reg_busy[rename_rd] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rename_en && rename_rd != '0) begin
			reg_tag[rename_rd] <= rename_tag;
		end
	end

endmodule

// ==== dispatch_stage.sv ====
////////////////////////////////////////
// rename, operand sourcing and stall
// holds one accepted instruction for a cycle
////////////////////////////////////////
module dispatch_stage
	import ooo_pkg::*;
(
	input  logic                 clock,
	input  logic                 rst,
	input  logic                 dispatch_valid,
	input  inst_op_e             inst_op,
	input  logic [REG_IDX_W-1:0] inst_rd,
	input  logic [REG_IDX_W-1:0] inst_rs1,
	input  logic [REG_IDX_W-1:0] inst_rs2,
	input  logic [XLEN-1:0]      inst_imm,
	input  logic                 rs1_busy,
	input  logic [ROB_TAG_W-1:0] rs1_tag,
	input  logic [XLEN-1:0]      rs1_value,
	input  logic                 rs2_busy,
	input  logic [ROB_TAG_W-1:0] rs2_tag,
	input  logic [XLEN-1:0]      rs2_value,
	input  logic [ROB_TAG_W-1:0] rob_tail_tag,
	input  logic [ROB_CNT_W-1:0] rob_free,
	input  logic                 rob_a_done,
	input  logic [XLEN-1:0]      rob_a_value,
	input  logic                 rob_b_done,
	input  logic [XLEN-1:0]      rob_b_value,
	input  logic [RS_CNT_W-1:0]  rs_free,
	input  logic                 cdb_valid,
	input  logic [ROB_TAG_W-1:0] cdb_tag,
	input  logic [XLEN-1:0]      cdb_value,
	output logic                 stall,
	output logic                 alloc_en,
	output logic                 rename_en,
	output logic [REG_IDX_W-1:0] rename_rd,
	output logic [ROB_TAG_W-1:0] rename_tag,
	output logic [ROB_TAG_W-1:0] rob_a_tag,
	output logic [ROB_TAG_W-1:0] rob_b_tag,
	output logic                 insert_en,
	output alu_op_e              insert_op,
	output logic [ROB_TAG_W-1:0] insert_tag,
	output logic                 a_ready,
	output logic [ROB_TAG_W-1:0] a_tag,
	output logic [XLEN-1:0]      a_value,
	output logic                 b_ready,
	output logic [ROB_TAG_W-1:0] b_tag,
	output logic [XLEN-1:0]      b_value
);

	logic accept;
	logic [XLEN:0] src1, src2, opb;
	alu_op_e now_op;
	logic a_hit, b_hit;

	// dispatch register
	logic held_valid;
	alu_op_e held_op;
	logic [ROB_TAG_W-1:0] held_tag, held_a_tag, held_b_tag;
	logic held_a_ready, held_b_ready;
	logic [XLEN-1:0] held_a_value, held_b_value;

	// ready and value from the regfile, else the done rob entry, else this cycle's bus
	function automatic logic [XLEN:0] resolve(
		input logic busy,
		input logic [ROB_TAG_W-1:0] tag,
		input logic [XLEN-1:0] reg_value,
		input logic done,
		input logic [XLEN-1:0] rob_value,
		input logic bus_valid,
		input logic [ROB_TAG_W-1:0] bus_tag,
		input logic [XLEN-1:0] bus_value
	);
		if (!busy) begin
			return {1'b1, reg_value};
		end else if (done) begin
			return {1'b1, rob_value};
		end else if (bus_valid && bus_tag == tag) begin
			return {1'b1, bus_value};
		end
		return {1'b0, {XLEN{1'b0}}};
	endfunction

	// second rs entry is reserved for the held instruction
	assign stall = (rob_free == '0) || (rs_free < RS_CNT_W'(2));
	assign accept = dispatch_valid && !stall;

	// rob allocation and rename share one strobe
	assign alloc_en = accept;
	assign rename_en = accept;
	assign rename_rd = inst_rd;
	assign rename_tag = rob_tail_tag;

	// producer lookups in the rob
	assign rob_a_tag = rs1_tag;
	assign rob_b_tag = rs2_tag;

	assign src1 = resolve(rs1_busy, rs1_tag, rs1_value, rob_a_done, rob_a_value,
		cdb_valid, cdb_tag, cdb_value);
	assign src2 = resolve(rs2_busy, rs2_tag, rs2_value, rob_b_done, rob_b_value,
		cdb_valid, cdb_tag, cdb_value);

	// immediate replaces rs2 for addi
	always_comb begin
		if (inst_op == op_addi) begin
			opb = {1'b1, inst_imm};
		end else begin
			opb = src2;
		end
	end

	always_comb begin
		case (inst_op)
			op_add, op_addi: now_op = alu_add;
			op_sub: now_op = alu_sub;
			op_and: now_op = alu_and;
			op_or: now_op = alu_or;
			op_xor: now_op = alu_xor;
			op_sll: now_op = alu_sll;
			op_srl: now_op = alu_srl;
			op_slt: now_op = alu_slt;
			default: now_op = alu_add;
		endcase
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			held_valid <= 1'b0;
		end else begin
			held_valid <= accept;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			held_op <= now_op;
			held_tag <= rob_tail_tag;
			held_a_ready <= src1[XLEN];
			held_a_tag <= rs1_tag;
			held_a_value <= src1[XLEN-1:0];
			held_b_ready <= opb[XLEN];
			held_b_tag <= rs2_tag;
			held_b_value <= opb[XLEN-1:0];
		end
	end

	////////////////////////////////////////
	// rs insertion with bus bypass
	////////////////////////////////////////
	assign insert_en = held_valid;
	assign insert_op = held_op;
	assign insert_tag = held_tag;

	// a result on the bus while held is taken on the way in
	assign a_hit = cdb_valid && !held_a_ready && cdb_tag == held_a_tag;
	assign b_hit = cdb_valid && !held_b_ready && cdb_tag == held_b_tag;

	assign a_ready = held_a_ready || a_hit;
	assign a_tag = held_a_tag;
	assign a_value = a_hit ? cdb_value : held_a_value;
	assign b_ready = held_b_ready || b_hit;
	assign b_tag = held_b_tag;
	assign b_value = b_hit ? cdb_value : held_b_value;

endmodule

// ==== ooo_core.sv ====
////////////////////////////////////////
// single-issue OoO slice, ALU ops only
// source must not drive dispatch_valid while stall is high
////////////////////////////////////////
module ooo_core
	import ooo_pkg::*;
(
	input  logic                    clock,
	input  logic                    rst,
	input  logic                    dispatch_valid,
	input  inst_op_e                inst_op,
	input  logic [REG_IDX_W-1:0]    inst_rd,
	input  logic [REG_IDX_W-1:0]    inst_rs1,
	input  logic [REG_IDX_W-1:0]    inst_rs2,
	input  logic [XLEN-1:0]         inst_imm,
	output logic                    stall,
	output logic                    commit_valid,
	output logic [REG_IDX_W-1:0]    commit_rd,
	output logic [XLEN-1:0]         commit_data,
	output logic [COMMIT_CNT_W-1:0] commit_count
);

	// register file read side
	logic rs1_busy, rs2_busy;
	logic [ROB_TAG_W-1:0] rs1_tag, rs2_tag;
	logic [XLEN-1:0] rs1_value, rs2_value;

	// rob lookups and allocation
	logic [ROB_TAG_W-1:0] rob_tail_tag, rob_a_tag, rob_b_tag, commit_tag;
	logic [ROB_CNT_W-1:0] rob_free;
	logic rob_a_done, rob_b_done;
	logic [XLEN-1:0] rob_a_value, rob_b_value;
	logic alloc_en, rename_en;
	logic [REG_IDX_W-1:0] rename_rd;
	logic [ROB_TAG_W-1:0] rename_tag;

	// dispatch register to rs
	logic [RS_CNT_W-1:0] rs_free;
	logic insert_en, a_ready, b_ready;
	alu_op_e insert_op;
	logic [ROB_TAG_W-1:0] insert_tag, a_tag, b_tag;
	logic [XLEN-1:0] a_value, b_value;

	// rs to alu, alu onto the common data bus
	logic issue_valid, cdb_valid;
	alu_op_e issue_op;
	logic [ROB_TAG_W-1:0] issue_tag, cdb_tag;
	logic [XLEN-1:0] issue_a, issue_b, cdb_value;

	dispatch_stage u_dispatch (.*);

	reg_state u_regs (.rs1_idx(inst_rs1), .rs2_idx(inst_rs2), .*);

	reservation_station u_rs (.*);

	reorder_buffer u_rob (.alloc_rd(rename_rd), .*);

	alu_unit u_alu (.*);

endmodule

// ==== ooo_core_tb.sv ====
////////////////////////////////////////
// testbench for ooo_core, checks every commit against a register model
// inputs change on the falling edge, outputs sampled there too
////////////////////////////////////////
module ooo_core_tb
	import ooo_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	// wait limits in clock cycles
	localparam int STALL_LIMIT = 200;
	localparam int DRAIN_LIMIT = 1000;
	localparam int RANDOM_COUNT = 200;
	localparam logic [XLEN-1:0] JUNK_IMM = 32'hA5A5_A5A5;

	logic clock;
	logic rst;
	logic dispatch_valid;
	inst_op_e inst_op;
	logic [REG_IDX_W-1:0] inst_rd;
	logic [REG_IDX_W-1:0] inst_rs1;
	logic [REG_IDX_W-1:0] inst_rs2;
	logic [XLEN-1:0] inst_imm;
	logic stall;
	logic commit_valid;
	logic [REG_IDX_W-1:0] commit_rd;
	logic [XLEN-1:0] commit_data;
	logic [COMMIT_CNT_W-1:0] commit_count;

	// model state and bookkeeping
	logic [XLEN-1:0] model_regs [REG_COUNT];
	logic [REG_IDX_W+XLEN-1:0] expected_q [$];
	string test_name;
	int seed;
	int accepted;
	int stall_cycles;
	int value_errors;
	int protocol_errors;

	ooo_core uut (
		.clock(clock),
		.rst(rst),
		.dispatch_valid(dispatch_valid),
		.inst_op(inst_op),
		.inst_rd(inst_rd),
		.inst_rs1(inst_rs1),
		.inst_rs2(inst_rs2),
		.inst_imm(inst_imm),
		.stall(stall),
		.commit_valid(commit_valid),
		.commit_rd(commit_rd),
		.commit_data(commit_data),
		.commit_count(commit_count)
	);

	// 20 ns period
	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////
	// one instruction in program order, returns {rd, value}
	function automatic logic [REG_IDX_W+XLEN-1:0] model_step(
		input inst_op_e op,
		input logic [REG_IDX_W-1:0] rd,
		input logic [REG_IDX_W-1:0] rs1,
		input logic [REG_IDX_W-1:0] rs2,
		input logic [XLEN-1:0] imm
	);
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [XLEN-1:0] r;
		// x0 is never written, so it stays zero here
		a = model_regs[rs1];
		b = (op == op_addi) ? imm : model_regs[rs2];
		case (op)
			op_add, op_addi: r = a + b;
			op_sub: r = a - b;
			op_and: r = a & b;
			op_or: r = a | b;
			op_xor: r = a ^ b;
			op_sll: r = a << b[4:0];
			op_srl: r = a >> b[4:0];
			op_slt: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			default: r = '0;
		endcase
		if (rd != '0) begin
			model_regs[rd] = r;
		end
		return {rd, r};
	endfunction

	task automatic print_error_counts();
		$display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
	endtask

	// a wait that ran out ends the run here
	task automatic stop_on_timeout(input string what);
		protocol_errors++;
		$display("timeout while %s in test %s", what, test_name);
		print_error_counts();
		$display("STATUS: FAIL");
		$finish;
	endtask

	////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////
	// waits for stall low, then drives one dispatch for a cycle
	task automatic issue_inst(
		input inst_op_e op,
		input logic [REG_IDX_W-1:0] rd,
		input logic [REG_IDX_W-1:0] rs1,
		input logic [REG_IDX_W-1:0] rs2,
		input logic [XLEN-1:0] imm
	);
		int waited;
		waited = 0;
		while (stall) begin
			stall_cycles++;
			waited++;
			if (waited > STALL_LIMIT) begin
				stop_on_timeout("waiting for stall to drop");
			end
			@(negedge clock);
		end
		dispatch_valid = 1'b1;
		inst_op = op;
		inst_rd = rd;
		inst_rs1 = rs1;
		inst_rs2 = rs2;
		inst_imm = imm;
		// stall cannot change before the edge, so this one is accepted
		expected_q.push_back(model_step(op, rd, rs1, rs2, imm));
		accepted++;
		@(negedge clock);
		dispatch_valid = 1'b0;
	endtask

	// runs until every expected commit was seen
	task automatic drain_commits();
		int waited;
		waited = 0;
		while (expected_q.size() != 0) begin
			waited++;
			if (waited > DRAIN_LIMIT) begin
				stop_on_timeout("draining outstanding commits");
			end
			@(negedge clock);
		end
		// count moves on the edge after the last commit
		@(negedge clock);
		if (commit_count !== COMMIT_CNT_W'(accepted)) begin
			value_errors++;
			$display("ERROR %s: commit_count expected %0d actual %0d",
				test_name, accepted, commit_count);
		end
	endtask

	////////////////////////////////////////
	// commit checker
	////////////////////////////////////////
	always @(negedge clock) begin
		logic [REG_IDX_W+XLEN-1:0] front;
		if (!rst && commit_valid === 1'b1) begin
			if (expected_q.size() == 0) begin
				protocol_errors++;
				$display("commit of x%0d arrived with nothing outstanding in test %s",
					commit_rd, test_name);
			end else begin
				front = expected_q.pop_front();
				if (commit_rd !== front[XLEN +: REG_IDX_W]) begin
					value_errors++;
					$display("ERROR %s: commit_rd expected %0d actual %0d",
						test_name, front[XLEN +: REG_IDX_W], commit_rd);
				end
				if (commit_data !== front[XLEN-1:0]) begin
					value_errors++;
					$display("ERROR %s: commit_data expected %h actual %h",
						test_name, front[XLEN-1:0], commit_data);
				end
			end
		end
	end

	////////////////////////////////////////
	// test sequence
	////////////////////////////////////////
	initial begin
		logic [XLEN-1:0] rnd;
		logic [XLEN-1:0] imm;
		seed = 37;
		accepted = 0;
		stall_cycles = 0;
		value_errors = 0;
		protocol_errors = 0;
		test_name = "reset";
		rst = 1'b1;
		dispatch_valid = 1'b0;
		inst_op = op_add;
		inst_rd = '0;
		inst_rs1 = '0;
		inst_rs2 = '0;
		inst_imm = '0;
		for (int i = 0; i < REG_COUNT; i++) begin
			model_regs[i] = '0;
		end
		repeat (2) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;
		@(negedge clock);

		// idle state after reset
		if (stall !== 1'b0) begin
			value_errors++;
			$display("ERROR %s: stall expected 0 actual %b", test_name, stall);
		end
		if (commit_valid !== 1'b0) begin
			value_errors++;
			$display("ERROR %s: commit_valid expected 0 actual %b", test_name, commit_valid);
		end
		if (commit_count !== '0) begin
			value_errors++;
			$display("ERROR %s: commit_count expected 0 actual %0d", test_name, commit_count);
		end

		// addi loads, rs2 points at a register it must ignore
		test_name = "opcodes";
		issue_inst(op_addi, 5'd1, 5'd0, 5'd31, 32'h1234_5678);
		issue_inst(op_addi, 5'd2, 5'd0, 5'd31, 32'h0F0F_00FF);
		issue_inst(op_addi, 5'd3, 5'd0, 5'd31, 32'hFFFF_FF9C);
		issue_inst(op_addi, 5'd4, 5'd0, 5'd31, 32'd37);
		issue_inst(op_addi, 5'd5, 5'd0, 5'd31, 32'hFFFF_0000);
		issue_inst(op_addi, 5'd6, 5'd0, 5'd31, 32'h00FF_FF00);
		// 0x23 shifts by 3 once masked to five bits
		issue_inst(op_addi, 5'd7, 5'd0, 5'd31, 32'h0000_0023);
		issue_inst(op_addi, 5'd8, 5'd0, 5'd31, 32'hFFFF_FFFB);
		issue_inst(op_add, 5'd10, 5'd1, 5'd2, JUNK_IMM);
		issue_inst(op_sub, 5'd11, 5'd3, 5'd4, JUNK_IMM);
		issue_inst(op_and, 5'd12, 5'd5, 5'd6, JUNK_IMM);
		issue_inst(op_or, 5'd13, 5'd5, 5'd6, JUNK_IMM);
		issue_inst(op_xor, 5'd14, 5'd1, 5'd2, JUNK_IMM);
		issue_inst(op_sll, 5'd15, 5'd1, 5'd7, JUNK_IMM);
		issue_inst(op_srl, 5'd16, 5'd5, 5'd7, JUNK_IMM);
		// signed compare both ways
		issue_inst(op_slt, 5'd17, 5'd8, 5'd4, JUNK_IMM);
		issue_inst(op_slt, 5'd18, 5'd4, 5'd8, JUNK_IMM);
		drain_commits();

		// dependent chains and early reuse of x1 and x2
		test_name = "chains";
		issue_inst(op_addi, 5'd1, 5'd0, 5'd0, 32'd7);
		issue_inst(op_addi, 5'd1, 5'd1, 5'd0, 32'd3);
		issue_inst(op_add, 5'd2, 5'd1, 5'd1, JUNK_IMM);
		issue_inst(op_sub, 5'd3, 5'd2, 5'd1, JUNK_IMM);
		issue_inst(op_addi, 5'd1, 5'd3, 5'd0, 32'hFFFF_FFFF);
		issue_inst(op_xor, 5'd4, 5'd1, 5'd2, JUNK_IMM);
		issue_inst(op_sll, 5'd5, 5'd4, 5'd1, JUNK_IMM);
		issue_inst(op_or, 5'd2, 5'd2, 5'd5, JUNK_IMM);
		issue_inst(op_slt, 5'd6, 5'd3, 5'd2, JUNK_IMM);
		issue_inst(op_add, 5'd1, 5'd1, 5'd1, JUNK_IMM);
		issue_inst(op_srl, 5'd7, 5'd1, 5'd6, JUNK_IMM);
		issue_inst(op_and, 5'd8, 5'd7, 5'd1, JUNK_IMM);
		drain_commits();

		// random load over x0..x4
		test_name = "random";
		stall_cycles = 0;
		for (int n = 0; n < RANDOM_COUNT; n++) begin
			rnd = $random(seed);
			imm = $random(seed);
			issue_inst(inst_op_e'(rnd[7:4] % 4'd9),
				REG_IDX_W'(rnd[10:8] % 3'd5),
				REG_IDX_W'(rnd[13:11] % 3'd5),
				REG_IDX_W'(rnd[16:14] % 3'd5),
				imm);
		end
		drain_commits();
		if (stall_cycles == 0) begin
			protocol_errors++;
			$display("stall never rose during the random load");
		end

		// x0 as destination and as source
		test_name = "x0";
		issue_inst(op_addi, 5'd0, 5'd0, 5'd0, 32'd123);
		issue_inst(op_add, 5'd0, 5'd1, 5'd2, JUNK_IMM);
		issue_inst(op_add, 5'd9, 5'd0, 5'd1, JUNK_IMM);
		issue_inst(op_addi, 5'd10, 5'd0, 5'd0, 32'd5);
		issue_inst(op_or, 5'd0, 5'd10, 5'd10, JUNK_IMM);
		issue_inst(op_sub, 5'd11, 5'd0, 5'd0, JUNK_IMM);
		issue_inst(op_addi, 5'd12, 5'd0, 5'd9, 32'd0);
		drain_commits();

		print_error_counts();
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== ooo_core.f ====
ooo_pkg.sv
alu_unit.sv
reorder_buffer.sv
reservation_station.sv
reg_state.sv
dispatch_stage.sv
ooo_core.sv
ooo_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build ooo_core_tb with Verilator, run it and judge the result from sim.log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f ooo_core.f --top-module ooo_core_tb -o ooo_core_sim \
	&& ./obj_dir/ooo_core_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -qx "STATUS: PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
